/* Makefile */
# Verilator build and run for the chip configuration testbench

VERILATOR ?= verilator
TOP       ?= cs_config_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps
PASS_MSG  ?= Simulation finished: PASS

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Output goes to the console; the status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/cs_config_tb.sv */
module cs_config_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_cmds    = 40;
  localparam int wait_cycles = 2000;  // A command takes about 550 cycles

  logic       clk;
  logic       reset;
  logic [7:0] cmd_filt;
  logic [7:0] cmd_mix0;
  logic [7:0] cmd_mix1;
  logic [7:0] cmd_reg4;
  logic [7:0] cmd_reg5;
  logic [7:0] cmd_reg6;
  logic [7:0] cmd_reg7;
  logic       cmd_req;
  logic       cmd_ack;
  logic       spi_cs_n;
  logic       spi_sclk;
  logic       spi_mosi;
  logic [3:0] devid;
  logic       dev_grp;
  int         pass_cnt;
  int         fail_cnt;
  int         pending;
  int         seed = 40;
  bit         timed_out = 1'b0;

  cs_config_top UUT (
    .clk, .reset,
    .cmd_filt, .cmd_mix0, .cmd_mix1, .cmd_reg4, .cmd_reg5, .cmd_reg6, .cmd_reg7,
    .cmd_req, .cmd_ack,
    .spi_cs_n, .spi_sclk, .spi_mosi,
    .devid, .dev_grp
  );

  cs_spi_monitor u_mon (  // Watches the DUT ports only
    .clk, .reset,
    .cmd_filt, .cmd_mix0, .cmd_mix1, .cmd_reg4, .cmd_reg5, .cmd_reg6, .cmd_reg7,
    .cmd_req, .cmd_ack,
    .spi_cs_n, .spi_sclk, .spi_mosi,
    .devid, .dev_grp,
    .pass_cnt, .fail_cnt, .pending
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  function automatic logic [7:0] rand_byte();
    int r;
    r = $random(seed);
    return r[7:0];
  endfunction

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    while (cmd_ack !== level && n < wait_cycles) begin
      @(posedge clk);
      n++;
    end
    if (cmd_ack !== level) begin
      $display("Timeout: cmd_ack did not go to %b within %0d cycles", level, wait_cycles);
      timed_out = 1'b1;
    end
  endtask

  // Last frame still shifting after the final ack
  task automatic drain_frames();
    int n;
    n = 0;
    while (pending != 0 && n < wait_cycles) begin
      @(posedge clk);
      n++;
    end
    if (pending != 0) begin
      $display("Timeout: %0d expected frames never appeared on the serial link", pending);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_cmd(input int idx);
    logic [7:0] mix0;
    mix0 = rand_byte();
    if (idx < 16) mix0[7:4] = idx[3:0];  // Sweep every ADC option once
    @(posedge clk);
    cmd_filt <= rand_byte();
    cmd_mix0 <= mix0;
    cmd_mix1 <= rand_byte();
    cmd_reg4 <= rand_byte();
    cmd_reg5 <= rand_byte();
    cmd_reg6 <= rand_byte();
    cmd_reg7 <= rand_byte();
    cmd_req  <= 1'b1;  // Bytes valid with req
    wait_ack(1'b1);
    if (!timed_out) begin
      @(posedge clk);
      cmd_req <= 1'b0;
      wait_ack(1'b0);
    end
  endtask

  initial begin
    reset    = 1'b1;
    cmd_filt = 8'h00;
    cmd_mix0 = 8'h00;
    cmd_mix1 = 8'h00;
    cmd_reg4 = 8'h00;
    cmd_reg5 = 8'h00;
    cmd_reg6 = 8'h00;
    cmd_reg7 = 8'h00;
    cmd_req  = 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    repeat (6) @(posedge clk);  // Quiet link with req low
    for (int i = 0; i < num_cmds && !timed_out; i++) run_cmd(i);
    if (!timed_out) drain_frames();
    $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (timed_out || fail_cnt != 0 || pass_cnt != num_cmds + 1) begin
      $display("Simulation finished: FAIL");
    end else begin
      $display("Simulation finished: PASS");
    end
    $finish;
  end

endmodule

/* bench/cs_spi_monitor.sv */
module cs_spi_monitor (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] cmd_filt,
  input  logic [7:0] cmd_mix0,
  input  logic [7:0] cmd_mix1,
  input  logic [7:0] cmd_reg4,
  input  logic [7:0] cmd_reg5,
  input  logic [7:0] cmd_reg6,
  input  logic [7:0] cmd_reg7,
  input  logic       cmd_req,
  input  logic       cmd_ack,
  input  logic       spi_cs_n,
  input  logic       spi_sclk,
  input  logic       spi_mosi,
  input  logic [3:0] devid,
  input  logic       dev_grp,
  output int         pass_cnt,  // Tests passed
  output int         fail_cnt,
  output int         pending    // Frames still expected on the wire
);
  timeunit 1ns;
  timeprecision 100ps;

  // Model tables, entry 0 in the low byte
  localparam logic [127:0] adc1_tab = 128'h02_03_03_04_08_08_08_10_20;
  localparam logic [127:0] adc2_tab = 128'h04_07_10_12_1A_20_28_28_28;
  localparam logic [127:0] bw8_tab  = 128'h0B_11_16_21_03_0D_1B_01_2E_29_1E_06_2A_18_2C_26;
  localparam logic [127:0] bw9_tab  = 128'h00_00_00_00_01_01_01_02_02_03_05_09_0A_0D_11_1A;
  localparam logic [127:0] bw10_tab = 128'h08_10_17_25_0D_19_2C_17_1E_24_2B_02_05_07_08_05;
  localparam logic [127:0] bw11_tab = 128'h00_00_00_00_01_01_01_02_03_04_06_0B_0D_10_15_1F;
  localparam logic [127:0] bw12_tab = 128'h0D_0F_12_19_22_36_3E_05_12_28_14_2A_08_2C_23_38;
  localparam logic [127:0] bw13_tab = 128'h00_00_00_00_00_00_00_01_01_01_02_02_03_06_11_36;

  logic [15:0] exp_q [$];  // Expected frames in send order
  logic [15:0] shreg;      // Frame bits as they arrive
  logic [7:0]  mix1_s;     // mix1 of the command in flight
  logic        req_d;
  logic        ack_d;
  logic        sclk_d;
  logic        csn_d;
  logic        rst_chk;    // Idle state still to be checked
  int          nbits;
  int          starts;     // Frame starts since cmd_req rose
  int          cmd_errs;
  int          done_cmds;

  function automatic logic [7:0] table_entry(input logic [127:0] tab, input logic [3:0] idx);
    logic [6:0] base;
    base = {idx, 3'b000};
    return tab[base +: 8];
  endfunction

  // Seven table bits under the DOUT enable
  function automatic logic [7:0] bw_reg(input logic dout, input logic [127:0] tab,
                                        input logic [3:0] idx);
    logic [7:0] e;
    e = table_entry(tab, idx);
    return {dout, e[6:0]};
  endfunction

  task automatic expect_reg(input logic [5:0] addr, input logic [7:0] data);
    exp_q.push_back({2'b10, addr, data});  // Write opcode first
  endtask

  task automatic expect_image();
    logic [3:0] opt;
    opt = (cmd_mix0[7:4] > 4'd8) ? 4'd8 : cmd_mix0[7:4];  // 9 to 15 act as 8
    mix1_s = cmd_mix1;
    starts = 0;
    expect_reg(6'd0, 8'hDE);
    expect_reg(6'd1, table_entry(adc1_tab, opt) & 8'h3F);
    expect_reg(6'd2, table_entry(adc2_tab, opt) & 8'h3F);
    expect_reg(6'd3, {6'd0, cmd_mix1[3:2]});  // DIN
    expect_reg(6'd4, cmd_reg4);
    expect_reg(6'd5, cmd_reg5);
    expect_reg(6'd6, cmd_reg6);
    expect_reg(6'd7, cmd_reg7);
    expect_reg(6'd8, bw_reg(cmd_mix0[3], bw8_tab, cmd_filt[7:4]));
    expect_reg(6'd9, bw_reg(cmd_mix0[3], bw9_tab, cmd_filt[7:4]));
    expect_reg(6'd10, bw_reg(cmd_mix0[2], bw10_tab, cmd_filt[7:4]));
    expect_reg(6'd11, bw_reg(cmd_mix0[2], bw11_tab, cmd_filt[7:4]));
    expect_reg(6'd12, bw_reg(cmd_mix0[1], bw12_tab, cmd_filt[3:0]));  // Lower bw
    expect_reg(6'd13, bw_reg(cmd_mix0[1], bw13_tab, cmd_filt[3:0]));
    expect_reg(6'd14, 8'hFF);  // Amplifier power
  endtask

  task automatic report_test(input string name, input int errs);
    if (errs == 0) begin
      $display("%s: passed", name);
      pass_cnt++;
    end else begin
      $display("%s: failed with %0d errors", name, errs);
      fail_cnt++;
    end
  endtask

  task automatic verify_idle();
    int errs;
    errs = 0;
    if (cmd_ack !== 1'b0) begin
      $display("** Error reset cmd_ack: expected 0, actual %b", cmd_ack);
      errs++;
    end
    if (spi_cs_n !== 1'b1 || spi_sclk !== 1'b0) begin
      $display("** Error reset cs_n/sclk: expected 10, actual %b%b", spi_cs_n, spi_sclk);
      errs++;
    end
    if (devid !== 4'h0 || dev_grp !== 1'b0) begin
      $display("** Error reset devid/grp: expected 0/0, actual %h/%b", devid, dev_grp);
      errs++;
    end
    report_test("reset", errs);
    rst_chk = 1'b0;
  endtask

  task automatic ack_timing();
    if (starts != 15) begin  // 15th frame must be under way
      $display("cmd_ack rose after %0d frame starts instead of 15", starts);
      cmd_errs++;
    end
    if (devid !== mix1_s[7:4]) begin
      $display("** Error cmd %0d devid: expected %h, actual %h", done_cmds, mix1_s[7:4], devid);
      cmd_errs++;
    end
    if (dev_grp !== mix1_s[1]) begin
      $display("** Error cmd %0d dev_grp: expected %b, actual %b", done_cmds, mix1_s[1], dev_grp);
      cmd_errs++;
    end
  endtask

  task automatic compare_frame();
    logic [15:0] want;
    if (exp_q.size() == 0) return;  // Stray frame, counted at its start
    want = exp_q.pop_front();
    if (shreg !== want) begin
      $display("** Error cmd %0d reg %0d: expected %h, actual %h", done_cmds, want[13:8],
               want, shreg);
      cmd_errs++;
    end
    if (want[13:8] == 6'd14) begin  // Last register closes the test
      report_test($sformatf("cmd %0d", done_cmds), cmd_errs);
      cmd_errs = 0;
      done_cmds++;
    end
  endtask

  // Edges found from clock-sampled values
  always @(posedge clk) begin
    req_d  <= cmd_req;
    ack_d  <= cmd_ack;
    sclk_d <= spi_sclk;
    csn_d  <= spi_cs_n;
    if (reset) begin
      rst_chk = 1'b1;
      exp_q.delete();
      nbits = 0;
      starts = 0;
      cmd_errs = 0;
      done_cmds = 0;
      pass_cnt = 0;
      fail_cnt = 0;
    end else begin
      if (rst_chk) verify_idle();
      if (cmd_req && !req_d) expect_image();
      if (cmd_ack && !ack_d) ack_timing();
      if (!cmd_ack && ack_d && cmd_req) begin
        $display("cmd_ack fell while cmd_req was still high");
        cmd_errs++;
      end
      if (!spi_cs_n && csn_d) begin  // Frame start
        if (exp_q.size() == 0) begin
          $display("A frame started with no command pending");
          fail_cnt++;
        end
        starts++;
        nbits = 0;
      end
      if (spi_sclk && !sclk_d && !spi_cs_n) begin  // Chip samples here
        shreg = {shreg[14:0], spi_mosi};
        nbits++;
        if (nbits == 16) compare_frame();
      end
    end
    pending <= exp_q.size();
  end

endmodule

/* compile.f */
verilog/cs_cmd_pkg.sv
verilog/cs_chip_pkg.sv
verilog/cs_cmd2reg.sv
verilog/cs_cmd_port.sv
verilog/cs_reg_sequencer.sv
verilog/cs_spi_write.sv
verilog/cs_config_top.sv
bench/cs_spi_monitor.sv
bench/cs_config_tb.sv

/* verilog/cs_chip_pkg.sv */
package cs_chip_pkg;

  typedef logic [5:0]  reg_addr_t;   // Chip register address
  typedef logic [7:0]  reg_data_t;   // Chip register value
  typedef logic [15:0] spi_frame_t;  // {opcode[1:0], addr[5:0], data[7:0]}

  localparam int reg_count  = 15;  // Registers 0 to 14 per command
  localparam int frame_bits = 16;  // Bits per serial frame
  localparam int spi_gap_cycles = 2;  // Chip select high time between frames

  typedef logic [$clog2(frame_bits)-1:0] bit_cnt_t;  // Bit and gap counter

  localparam logic [1:0] spi_wr_opcode = 2'b10;  // Write opcode
  localparam reg_data_t  reg0_value    = 8'hDE;  // Fixed register 0 setting
  localparam reg_data_t  regap_value   = 8'hFF;  // All amplifiers powered

  // ADC option tables, one byte per option, option 0 in the low byte
  // Only the low 6 bits of each entry are used
  localparam logic [71:0] adc_table_1 = 72'h02_03_03_04_08_08_08_10_20;  // ADC bias
  localparam logic [71:0] adc_table_2 = 72'h04_07_10_12_1A_20_28_28_28;  // MUX bias

  // Upper bandwidth tables, indexed by filt[7:4], low 7 bits used
  localparam logic [127:0] bw_table_8 =
    128'h0B_11_16_21_03_0D_1B_01_2E_29_1E_06_2A_18_2C_26;
  localparam logic [127:0] bw_table_9 =
    128'h00_00_00_00_01_01_01_02_02_03_05_09_0A_0D_11_1A;
  localparam logic [127:0] bw_table_10 =
    128'h08_10_17_25_0D_19_2C_17_1E_24_2B_02_05_07_08_05;
  localparam logic [127:0] bw_table_11 =
    128'h00_00_00_00_01_01_01_02_03_04_06_0B_0D_10_15_1F;

  // Lower bandwidth tables, indexed by filt[3:0]
  localparam logic [127:0] bw_table_12 =
    128'h0D_0F_12_19_22_36_3E_05_12_28_14_2A_08_2C_23_38;
  localparam logic [127:0] bw_table_13 =
    128'h00_00_00_00_00_00_00_01_01_01_02_02_03_06_11_36;

  typedef enum logic [1:0] {
    seq_idle,  // Waiting for start
    seq_send,  // Offering frames for addresses 0 to 14
    seq_done   // One cycle, done pulse
  } seq_state_t;

  typedef enum logic [1:0] {
    spi_idle,   // Ready for a frame
    spi_shift,  // Clocking out the 16 bits
    spi_gap     // Chip select high before next frame
  } spi_state_t;

endpackage

/* verilog/cs_cmd2reg.sv */
module cs_cmd2reg import cs_cmd_pkg::*, cs_chip_pkg::*; (
  input  cmd_byte_t filt_q,   // [7:4] upper bw  [3:0] lower bw
  input  cmd_byte_t mix0_q,   // [7:4] ADC option  [3:1] DOUT
  input  cmd_byte_t mix1_q,   // [7:4] id  [3:2] DIN  [1] group
  input  cmd_byte_t reg4_q,
  input  cmd_byte_t reg5_q,
  input  cmd_byte_t reg6_q,
  input  cmd_byte_t reg7_q,
  output reg_data_t reg00,
  output reg_data_t reg01,
  output reg_data_t reg02,
  output reg_data_t reg03,
  output reg_data_t reg04,
  output reg_data_t reg05,
  output reg_data_t reg06,
  output reg_data_t reg07,
  output reg_data_t reg08,
  output reg_data_t reg09,
  output reg_data_t reg10,
  output reg_data_t reg11,
  output reg_data_t reg12,
  output reg_data_t reg13,
  output reg_data_t regap,    // Per-amplifier power
  output dev_id_t   devid,
  output logic      dev_grp
);

  bw_code_t up_bw;    // Upper bandwidth code
  bw_code_t lo_bw;    // Lower bandwidth code
  adc_opt_t adc_raw;  // Option as sent by host
  adc_opt_t adc_opt;  // Option after clamp

  assign up_bw   = filt_q[7:4];
  assign lo_bw   = filt_q[3:0];
  assign adc_raw = mix0_q[7:4];

  // Options 9 to 15 fall back to the fastest defined rate
  assign adc_opt = (adc_raw > adc_opt_max) ? adc_opt_max : adc_raw;

  assign reg00 = reg0_value;
  assign reg01 = {2'b00, adc_table_1[{adc_opt, 3'b000} +: 6]};  // Byte select, 6 bits used
  assign reg02 = {2'b00, adc_table_2[{adc_opt, 3'b000} +: 6]};
  assign reg03 = {6'b000000, mix1_q[3:2]};  // DIN

  // Raw bytes straight through
  assign reg04 = reg4_q;
  assign reg05 = reg5_q;
  assign reg06 = reg6_q;
  assign reg07 = reg7_q;

  // Bandwidth DACs, top bit is the DOUT enable of that pair
  assign reg08 = {mix0_q[3], bw_table_8[{up_bw, 3'b000} +: 7]};
  assign reg09 = {mix0_q[3], bw_table_9[{up_bw, 3'b000} +: 7]};
  assign reg10 = {mix0_q[2], bw_table_10[{up_bw, 3'b000} +: 7]};
  assign reg11 = {mix0_q[2], bw_table_11[{up_bw, 3'b000} +: 7]};
  assign reg12 = {mix0_q[1], bw_table_12[{lo_bw, 3'b000} +: 7]};  // Lower bw pair
  assign reg13 = {mix0_q[1], bw_table_13[{lo_bw, 3'b000} +: 7]};

  assign regap   = regap_value;
  assign devid   = mix1_q[7:4];
  assign dev_grp = mix1_q[1];

endmodule

/* verilog/cs_cmd_pkg.sv */
package cs_cmd_pkg;

  // Host command layout, seven bytes per command
  //   filt  [7:4] upper bandwidth code   [3:0] lower bandwidth code
  //   mix0  [7:4] ADC option             [3:1] DOUT bits per amplifier pair
  //   mix1  [7:4] device id              [3:2] DIN bits   [1] group
  //   reg4 to reg7 go to the chip unchanged

  typedef logic [7:0] cmd_byte_t;  // One host command byte

  typedef logic [3:0] bw_code_t;   // Upper or lower bandwidth code

  typedef logic [3:0] adc_opt_t;   // ADC sample-rate option

  typedef logic [3:0] dev_id_t;    // Device id out of mix1

  // Last option with a table entry (700 kS/s)
  localparam adc_opt_t adc_opt_max = 4'd8;

endpackage

/* verilog/cs_cmd_port.sv */
module cs_cmd_port import cs_cmd_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  cmd_byte_t cmd_filt,
  input  cmd_byte_t cmd_mix0,
  input  cmd_byte_t cmd_mix1,
  input  cmd_byte_t cmd_reg4,
  input  cmd_byte_t cmd_reg5,
  input  cmd_byte_t cmd_reg6,
  input  cmd_byte_t cmd_reg7,
  input  logic      cmd_req,
  output logic      cmd_ack,
  input  logic      done,     // Sequencer finished all registers
  output logic      start,    // Kick the sequencer
  output cmd_byte_t filt_q,
  output cmd_byte_t mix0_q,
  output cmd_byte_t mix1_q,
  output cmd_byte_t reg4_q,
  output cmd_byte_t reg5_q,
  output cmd_byte_t reg6_q,
  output cmd_byte_t reg7_q
);

  typedef enum logic [1:0] {
    port_idle,   // Waiting for cmd_req
    port_busy,   // Chip being written
    port_acked   // Ack held until host drops req
  } port_state_t;

  port_state_t state_q;
  logic        take_cmd;  // Accept this cycle

  assign take_cmd = (state_q == port_idle) && cmd_req;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= port_idle;
      cmd_ack <= 1'b0;
      start   <= 1'b0;
    end else begin
      start <= 1'b0;  // Pulse only
      case (state_q)
        port_idle: begin
          if (take_cmd) begin
            start   <= 1'b1;
            state_q <= port_busy;
          end
        end
        port_busy: begin
          if (done) begin
            cmd_ack <= 1'b1;  // Up the cycle after done
            state_q <= port_acked;
          end
        end
        port_acked: begin
          if (!cmd_req) begin
            cmd_ack <= 1'b0;
            state_q <= port_idle;
          end
        end
        default: state_q <= port_idle;
      endcase
    end
  end

  // Command bytes held for the whole write sequence
  always_ff @(posedge clk) begin
    if (reset) begin
      filt_q <= '0;
      mix0_q <= '0;
      mix1_q <= '0;  // devid and group read zero
      reg4_q <= '0;
      reg5_q <= '0;
      reg6_q <= '0;
      reg7_q <= '0;
    end else if (take_cmd) begin
      filt_q <= cmd_filt;
      mix0_q <= cmd_mix0;
      mix1_q <= cmd_mix1;
      reg4_q <= cmd_reg4;
      reg5_q <= cmd_reg5;
      reg6_q <= cmd_reg6;
      reg7_q <= cmd_reg7;
    end
  end

endmodule

/* verilog/cs_config_top.sv */
module cs_config_top import cs_cmd_pkg::*, cs_chip_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  cmd_byte_t cmd_filt,
  input  cmd_byte_t cmd_mix0,
  input  cmd_byte_t cmd_mix1,
  input  cmd_byte_t cmd_reg4,
  input  cmd_byte_t cmd_reg5,
  input  cmd_byte_t cmd_reg6,
  input  cmd_byte_t cmd_reg7,
  input  logic      cmd_req,
  output logic      cmd_ack,
  output logic      spi_cs_n,
  output logic      spi_sclk,
  output logic      spi_mosi,
  output dev_id_t   devid,
  output logic      dev_grp
);

  logic       start;
  logic       done;
  cmd_byte_t  filt_q, mix0_q, mix1_q;  // Latched command
  cmd_byte_t  reg4_q, reg5_q, reg6_q, reg7_q;
  reg_data_t  reg00, reg01, reg02, reg03, reg04, reg05, reg06, reg07;
  reg_data_t  reg08, reg09, reg10, reg11, reg12, reg13, regap;
  spi_frame_t frame;
  logic       frame_valid;
  logic       frame_ready;

  cs_cmd_port u_port (
    .clk, .reset,
    .cmd_filt, .cmd_mix0, .cmd_mix1,
    .cmd_reg4, .cmd_reg5, .cmd_reg6, .cmd_reg7,
    .cmd_req, .cmd_ack, .done, .start,
    .filt_q, .mix0_q, .mix1_q, .reg4_q, .reg5_q, .reg6_q, .reg7_q
  );

  cs_cmd2reg u_cmd2reg (  // Chip image from the latched bytes
    .filt_q, .mix0_q, .mix1_q, .reg4_q, .reg5_q, .reg6_q, .reg7_q,
    .reg00, .reg01, .reg02, .reg03, .reg04, .reg05, .reg06, .reg07,
    .reg08, .reg09, .reg10, .reg11, .reg12, .reg13, .regap,
    .devid, .dev_grp
  );

  cs_reg_sequencer u_seq (
    .clk, .reset, .start, .done,
    .reg00, .reg01, .reg02, .reg03, .reg04, .reg05, .reg06, .reg07,
    .reg08, .reg09, .reg10, .reg11, .reg12, .reg13, .regap,
    .frame, .frame_valid, .frame_ready
  );

  cs_spi_write u_spi (  // Serial link to the chip
    .clk, .reset,
    .frame, .frame_valid, .frame_ready,
    .spi_cs_n, .spi_sclk, .spi_mosi
  );

endmodule

/* verilog/cs_reg_sequencer.sv */
module cs_reg_sequencer import cs_chip_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       start,
  output logic       done,
  input  reg_data_t  reg00,
  input  reg_data_t  reg01,
  input  reg_data_t  reg02,
  input  reg_data_t  reg03,
  input  reg_data_t  reg04,
  input  reg_data_t  reg05,
  input  reg_data_t  reg06,
  input  reg_data_t  reg07,
  input  reg_data_t  reg08,
  input  reg_data_t  reg09,
  input  reg_data_t  reg10,
  input  reg_data_t  reg11,
  input  reg_data_t  reg12,
  input  reg_data_t  reg13,
  input  reg_data_t  regap,
  output spi_frame_t frame,
  output logic       frame_valid,
  input  logic       frame_ready
);

  seq_state_t state_q;
  reg_addr_t  addr_q;    // Register being written
  reg_data_t  reg_data;  // Value at addr_q
  logic       xfer;      // Frame accepted by the serial writer
  logic       last;      // Final register

  assign xfer = frame_valid && frame_ready;
  assign last = (addr_q == reg_addr_t'(reg_count - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= seq_idle;
      addr_q  <= '0;
    end else begin
      case (state_q)
        seq_idle: begin
          if (start) begin
            addr_q  <= '0;
            state_q <= seq_send;
          end
        end
        seq_send: begin
          if (xfer) begin
            if (last) state_q <= seq_done;
            else      addr_q  <= addr_q + 1'b1;  // Next register
          end
        end
        seq_done: state_q <= seq_idle;  // Single cycle
        default:  state_q <= seq_idle;
      endcase
    end
  end

  // Register image select
  always_comb begin
    case (addr_q)
      6'd0:    reg_data = reg00;
      6'd1:    reg_data = reg01;
      6'd2:    reg_data = reg02;
      6'd3:    reg_data = reg03;
      6'd4:    reg_data = reg04;
      6'd5:    reg_data = reg05;
      6'd6:    reg_data = reg06;
      6'd7:    reg_data = reg07;
      6'd8:    reg_data = reg08;
      6'd9:    reg_data = reg09;
      6'd10:   reg_data = reg10;
      6'd11:   reg_data = reg11;
      6'd12:   reg_data = reg12;
      6'd13:   reg_data = reg13;
      6'd14:   reg_data = regap;  // Amplifier power
      default: reg_data = '0;
    endcase
  end

  assign frame       = {spi_wr_opcode, addr_q, reg_data};
  assign frame_valid = (state_q == seq_send);
  assign done        = (state_q == seq_done);

endmodule

/* verilog/cs_spi_write.sv */
module cs_spi_write import cs_chip_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  spi_frame_t frame,
  input  logic       frame_valid,
  output logic       frame_ready,
  output logic       spi_cs_n,
  output logic       spi_sclk,
  output logic       spi_mosi
);

  spi_state_t state_q;
  spi_frame_t shift_q;  // MSB is on the line
  bit_cnt_t   cnt_q;    // Bits sent, then gap cycles
  logic       last_bit;
  logic       gap_end;

  assign last_bit = (cnt_q == bit_cnt_t'(frame_bits - 1));
  assign gap_end  = (cnt_q == bit_cnt_t'(spi_gap_cycles - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q  <= spi_idle;
      shift_q  <= '0;
      cnt_q    <= '0;
      spi_cs_n <= 1'b1;
      spi_sclk <= 1'b0;
    end else begin
      case (state_q)
        spi_idle: begin
          if (frame_valid) begin
            shift_q  <= frame;  // Bit 15 out before first rise
            cnt_q    <= '0;
            spi_cs_n <= 1'b0;
            state_q  <= spi_shift;
          end
        end
        spi_shift: begin
          spi_sclk <= ~spi_sclk;  // Toggle every cycle
          if (spi_sclk) begin
            // Falling edge moves the next bit onto mosi
            shift_q <= {shift_q[frame_bits-2:0], 1'b0};
            if (last_bit) begin
              spi_cs_n <= 1'b1;
              cnt_q    <= '0;
              state_q  <= spi_gap;
            end else begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
        end
        spi_gap: begin
          if (gap_end) state_q <= spi_idle;
          else         cnt_q   <= cnt_q + 1'b1;
        end
        default: state_q <= spi_idle;
      endcase
    end
  end

  assign frame_ready = (state_q == spi_idle);
  assign spi_mosi    = shift_q[frame_bits-1];

endmodule
